/* cp_pkg.sv */
`default_nettype none

package cp_pkg;

  localparam int NUM_COL     = 2;   // compute columns
  localparam int INSTR_W     = 32;
  localparam int PHIT_W      = 64;  // two instructions per beat
  localparam int TABLE_DEPTH = 32;
  localparam int TABLE_AW    = 5;
  localparam int PC_W        = 12;
  localparam int BURST_LEN   = 16;  // beats per image
  localparam int M_AXI_AW    = 64;
  localparam int S_AXI_AW    = 6;
  localparam int S_AXI_DW    = 32;
  localparam int CNT_W       = 32;

  localparam logic [S_AXI_AW-1:0] ADDR_CTRL   = 6'h00;
  localparam logic [S_AXI_AW-1:0] ADDR_GIE    = 6'h04;
  localparam logic [S_AXI_AW-1:0] ADDR_IER    = 6'h08;
  localparam logic [S_AXI_AW-1:0] ADDR_ISR    = 6'h0C;
  localparam logic [S_AXI_AW-1:0] ADDR_PTR_LO = 6'h10;
  localparam logic [S_AXI_AW-1:0] ADDR_PTR_HI = 6'h14;

  localparam int CTRL_START = 0;
  localparam int CTRL_DONE  = 1;
  localparam int CTRL_IDLE  = 2;
  localparam int CTRL_READY = 3;

  typedef logic [INSTR_W-1:0]  instr_t;
  typedef logic [PHIT_W-1:0]   phit_t;
  typedef logic [TABLE_AW-1:0] tbl_addr_t;
  typedef logic [PC_W-1:0]     pc_t;
  typedef logic [M_AXI_AW-1:0] maddr_t;
  typedef logic [CNT_W-1:0]    cnt_t;

endpackage

`default_nettype wire

/* instr_table_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface instr_table_if;

  logic              wr_en;
  cp_pkg::tbl_addr_t wr_addr;    // lower of the two slots
  cp_pkg::phit_t     wr_data;
  logic              fill_done;  // full image present

  modport producer (
    output wr_en,
    output wr_addr,
    output wr_data,
    output fill_done
  );

  modport buffer (
    input wr_en,
    input wr_addr,
    input wr_data,
    input fill_done
  );

endinterface

`default_nettype wire

/* control_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module control_regs (
  input  wire                             ap_clk,
  input  wire                             areset,
  input  wire  [cp_pkg::S_AXI_AW-1:0]     awaddr,
  input  wire                             awvalid,
  input  wire  [cp_pkg::S_AXI_DW-1:0]     wdata,
  input  wire  [cp_pkg::S_AXI_DW/8-1:0]   wstrb,
  input  wire                             wvalid,
  input  wire                             bready,
  input  wire  [cp_pkg::S_AXI_AW-1:0]     araddr,
  input  wire                             arvalid,
  input  wire                             rready,
  input  wire                             done_loader,
  output logic                            awready,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  output logic                            arready,
  output logic [cp_pkg::S_AXI_DW-1:0]     rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  output logic                            interrupt,
  output cp_pkg::maddr_t                  ptr,
  output logic                            ap_start_pulse
);

  logic [cp_pkg::S_AXI_DW-1:0] wmask;
  logic [cp_pkg::S_AXI_DW-1:0] rdata_next;
  logic                        wr_hs;
  logic                        rd_hs;
  logic                        ctrl_rd;
  logic                        ap_start;
  logic                        ap_start_r;
  logic                        ap_idle;
  logic                        ap_done;
  logic                        ap_ready;
  logic                        gie;
  logic [1:0]                  ier;
  logic [1:0]                  isr;   // bit 0 done, bit 1 ready

  assign wr_hs   = awvalid & awready;  // aw and w go together
  assign rd_hs   = arvalid & arready;
  assign ctrl_rd = rd_hs && (araddr == cp_pkg::ADDR_CTRL);

  assign bresp = 2'b00;  // always okay
  assign rresp = 2'b00;

  always_comb begin
    for (int i = 0; i < cp_pkg::S_AXI_DW / 8; i++) begin
      wmask[8*i +: 8] = {8{wstrb[i]}};
    end
  end

  // write channel handshake
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      wready  <= awvalid & wvalid & ~awready & ~bvalid;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // read channel handshake
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~arready & ~rvalid;  // one response in flight
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rdata_next = '0;
    case (araddr)
      cp_pkg::ADDR_CTRL: begin
        rdata_next[cp_pkg::CTRL_START] = ap_start;
        rdata_next[cp_pkg::CTRL_DONE]  = ap_done;
        rdata_next[cp_pkg::CTRL_IDLE]  = ap_idle;
        rdata_next[cp_pkg::CTRL_READY] = ap_ready;
      end
      cp_pkg::ADDR_GIE:    rdata_next[0]   = gie;
      cp_pkg::ADDR_IER:    rdata_next[1:0] = ier;
      cp_pkg::ADDR_ISR:    rdata_next[1:0] = isr;
      cp_pkg::ADDR_PTR_LO: rdata_next      = ptr[31:0];
      cp_pkg::ADDR_PTR_HI: rdata_next      = ptr[63:32];
      default:             rdata_next      = '0;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (rd_hs) begin
      rdata <= rdata_next;  // held until rready
    end
  end

  always_ff @(posedge ap_clk) begin
    if (wr_hs && awaddr == cp_pkg::ADDR_PTR_LO) begin
      ptr[31:0] <= (ptr[31:0] & ~wmask) | (wdata & wmask);
    end
    if (wr_hs && awaddr == cp_pkg::ADDR_PTR_HI) begin
      ptr[63:32] <= (ptr[63:32] & ~wmask) | (wdata & wmask);
    end
  end

  // kernel start / done / idle bookkeeping
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start   <= 1'b0;
      ap_start_r <= 1'b0;
      ap_idle    <= 1'b1;
      ap_done    <= 1'b0;
      ap_ready   <= 1'b0;
    end else begin
      ap_start_r <= ap_start;
      if (done_loader) begin
        ap_start <= 1'b0;
      end else if (wr_hs && awaddr == cp_pkg::ADDR_CTRL && wstrb[0] &&
                   wdata[cp_pkg::CTRL_START]) begin
        ap_start <= 1'b1;
      end
      if (done_loader) begin
        ap_idle <= 1'b1;
      end else if (ap_start_pulse) begin
        ap_idle <= 1'b0;
      end
      if (done_loader) begin
        ap_done  <= 1'b1;  // sticky until ctrl is read
        ap_ready <= 1'b1;
      end else if (ctrl_rd) begin
        ap_done  <= 1'b0;
        ap_ready <= 1'b0;
      end
    end
  end

  assign ap_start_pulse = ap_start & ~ap_start_r;

  // interrupt registers
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      gie <= 1'b0;
      ier <= 2'b00;
      isr <= 2'b00;
    end else begin
      if (wr_hs && awaddr == cp_pkg::ADDR_GIE && wstrb[0]) begin
        gie <= wdata[0];
      end
      if (wr_hs && awaddr == cp_pkg::ADDR_IER && wstrb[0]) begin
        ier <= wdata[1:0];
      end
      if (done_loader) begin
        isr <= 2'b11;
      end else if (wr_hs && awaddr == cp_pkg::ADDR_ISR && wstrb[0]) begin
        isr <= isr ^ wdata[1:0];  // toggle on write 1
      end
    end
  end

  assign interrupt = gie & (|(ier & isr));

  a_bvalid_after_write: assert property (@(posedge ap_clk) disable iff (areset)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready));

endmodule

`default_nettype wire

/* instr_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    ap_start_pulse,
  input  wire cp_pkg::maddr_t    ptr,
  input  wire                    m_axi_arready,
  input  wire                    m_axi_rvalid,
  input  wire cp_pkg::phit_t     m_axi_rdata,
  input  wire                    m_axi_rlast,
  output logic                   m_axi_arvalid,
  output cp_pkg::maddr_t         m_axi_araddr,
  output logic [7:0]             m_axi_arlen,
  output logic                   m_axi_rready,
  output logic                   done_loader,
  output cp_pkg::cnt_t           cycle_register,
  instr_table_if.producer        tbl
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    DONE
  } state_t;

  state_t                      state;
  logic [cp_pkg::TABLE_AW-2:0] beat_cnt;  // beats within the burst
  logic                        beat_fire;
  logic                        launch;

  assign launch    = (state == IDLE) && ap_start_pulse;
  assign beat_fire = m_axi_rvalid & m_axi_rready;

  assign m_axi_arvalid = (state == ADDR);
  assign m_axi_rready  = (state == DATA);
  assign done_loader   = (state == DONE);
  assign m_axi_arlen   = 8'(cp_pkg::BURST_LEN - 1);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (ap_start_pulse) state <= ADDR;
        ADDR:    if (m_axi_arready) state <= DATA;
        DATA:    if (beat_fire && m_axi_rlast) state <= DONE;
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (launch) begin
      m_axi_araddr <= ptr;  // whole image in one burst
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_cnt       <= '0;
      tbl.wr_en      <= 1'b0;
      tbl.fill_done  <= 1'b0;
      cycle_register <= '0;
    end else begin
      tbl.wr_en <= beat_fire;
      if (launch) begin
        beat_cnt <= '0;
      end else if (beat_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (ap_start_pulse) begin
        tbl.fill_done <= 1'b0;
      end else if (done_loader) begin
        tbl.fill_done <= 1'b1;
      end
      if (launch) begin
        cycle_register <= cp_pkg::cnt_t'(1);
      end else if (state != IDLE) begin
        cycle_register <= cycle_register + 1'b1;  // holds once back in idle
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (beat_fire) begin
      tbl.wr_addr <= {beat_cnt, 1'b0};
      tbl.wr_data <= m_axi_rdata;
    end
  end

  a_arvalid_hold: assert property (@(posedge ap_clk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr));

  a_rlast_on_last_beat: assert property (@(posedge ap_clk) disable iff (areset)
    beat_fire |-> (m_axi_rlast == (int'(beat_cnt) == cp_pkg::BURST_LEN - 1)));

endmodule

`default_nettype wire

/* instr_table.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_table (
  input  wire                                          ap_clk,
  input  wire                                          areset,
  input  wire cp_pkg::tbl_addr_t [cp_pkg::NUM_COL-1:0] rd_addr,
  output cp_pkg::instr_t [cp_pkg::NUM_COL-1:0]         rd_data,
  instr_table_if.buffer                                tbl
);

  cp_pkg::instr_t    mem [cp_pkg::TABLE_DEPTH];
  cp_pkg::tbl_addr_t hi_addr;

  assign hi_addr = tbl.wr_addr + 1'b1;  // upper instruction of the beat

  always_ff @(posedge ap_clk) begin
    if (tbl.wr_en) begin
      mem[tbl.wr_addr] <= tbl.wr_data[cp_pkg::INSTR_W-1:0];
      mem[hi_addr]     <= tbl.wr_data[cp_pkg::PHIT_W-1:cp_pkg::INSTR_W];
    end
  end

  // partial image reads as nop
  always_comb begin
    for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
      rd_data[c] = tbl.fill_done ? mem[rd_addr[c]] : '0;
    end
  end

  a_no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset)
    tbl.wr_en |-> !tbl.fill_done);

endmodule

`default_nettype wire

/* pc_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer (
  input  wire                                          ap_clk,
  input  wire                                          areset,
  input  wire [cp_pkg::NUM_COL-1:0]                    clken_pc,
  input  wire [cp_pkg::NUM_COL-1:0]                    load_pc,
  input  wire [cp_pkg::NUM_COL-1:0]                    incr_pc,
  input  wire cp_pkg::pc_t [cp_pkg::NUM_COL-1:0]       load_value_pc,
  input  wire                                          done_steady,
  input  wire cp_pkg::instr_t [cp_pkg::NUM_COL-1:0]    rd_data,
  output cp_pkg::tbl_addr_t [cp_pkg::NUM_COL-1:0]      rd_addr,
  output cp_pkg::instr_t [cp_pkg::NUM_COL-1:0]         instr
);

  cp_pkg::pc_t pc [cp_pkg::NUM_COL];

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
        pc[c] <= '0;
      end
    end else begin
      for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
        if (clken_pc[c]) begin
          if (load_pc[c]) begin
            pc[c] <= load_value_pc[c];  // load beats incr
          end else if (incr_pc[c]) begin
            pc[c] <= pc[c] + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
      rd_addr[c] = pc[c][cp_pkg::TABLE_AW-1:0];  // wraps modulo table depth
      instr[c]   = done_steady ? '0 : rd_data[c];
    end
  end

endmodule

`default_nettype wire

/* control_plane.sv */
`timescale 1ns/10ps
`default_nettype none

module control_plane (
  input  wire                                          ap_clk,
  input  wire                                          areset,
  input  wire  [cp_pkg::S_AXI_AW-1:0]                  awaddr,
  input  wire                                          awvalid,
  input  wire  [cp_pkg::S_AXI_DW-1:0]                  wdata,
  input  wire  [cp_pkg::S_AXI_DW/8-1:0]                wstrb,
  input  wire                                          wvalid,
  input  wire                                          bready,
  input  wire  [cp_pkg::S_AXI_AW-1:0]                  araddr,
  input  wire                                          arvalid,
  input  wire                                          rready,
  output logic                                         awready,
  output logic                                         wready,
  output logic [1:0]                                   bresp,
  output logic                                         bvalid,
  output logic                                         arready,
  output logic [cp_pkg::S_AXI_DW-1:0]                  rdata,
  output logic [1:0]                                   rresp,
  output logic                                         rvalid,
  output logic                                         interrupt,
  input  wire                                          m_axi_arready,
  input  wire                                          m_axi_rvalid,
  input  wire cp_pkg::phit_t                           m_axi_rdata,
  input  wire                                          m_axi_rlast,
  output logic                                         m_axi_arvalid,
  output cp_pkg::maddr_t                               m_axi_araddr,
  output logic [7:0]                                   m_axi_arlen,
  output logic                                         m_axi_rready,
  input  wire                                          done_steady,
  input  wire  [cp_pkg::NUM_COL-1:0]                   clken_pc,
  input  wire  [cp_pkg::NUM_COL-1:0]                   load_pc,
  input  wire  [cp_pkg::NUM_COL-1:0]                   incr_pc,
  input  wire  [cp_pkg::NUM_COL*cp_pkg::PC_W-1:0]      load_value_pc,
  output cp_pkg::cnt_t                                 cycle_register,
  output logic [cp_pkg::NUM_COL*cp_pkg::INSTR_W-1:0]   instr,
  output logic                                         done_loader
);

  cp_pkg::maddr_t                              ptr;
  logic                                        ap_start_pulse;
  cp_pkg::tbl_addr_t [cp_pkg::NUM_COL-1:0]     rd_addr;
  cp_pkg::instr_t [cp_pkg::NUM_COL-1:0]        rd_data;

  instr_table_if tbl_if ();

  control_regs u_control_regs (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .rready         (rready),
    .done_loader    (done_loader),
    .awready        (awready),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .interrupt      (interrupt),
    .ptr            (ptr),
    .ap_start_pulse (ap_start_pulse)
  );

  instr_fetch u_instr_fetch (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .ap_start_pulse (ap_start_pulse),
    .ptr            (ptr),
    .m_axi_arready  (m_axi_arready),
    .m_axi_rvalid   (m_axi_rvalid),
    .m_axi_rdata    (m_axi_rdata),
    .m_axi_rlast    (m_axi_rlast),
    .m_axi_arvalid  (m_axi_arvalid),
    .m_axi_araddr   (m_axi_araddr),
    .m_axi_arlen    (m_axi_arlen),
    .m_axi_rready   (m_axi_rready),
    .done_loader    (done_loader),
    .cycle_register (cycle_register),
    .tbl            (tbl_if.producer)
  );

  instr_table u_instr_table (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .tbl     (tbl_if.buffer)
  );

  pc_sequencer u_pc_sequencer (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .clken_pc      (clken_pc),
    .load_pc       (load_pc),
    .incr_pc       (incr_pc),
    .load_value_pc (load_value_pc),
    .done_steady   (done_steady),
    .rd_data       (rd_data),
    .rd_addr       (rd_addr),
    .instr         (instr)
  );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
  input  wire         ap_clk,
  input  wire         areset,
  input  wire         arvalid,
  input  wire  [63:0] araddr,
  input  wire  [7:0]  arlen,
  input  wire         rready,
  output logic        arready,
  output logic        rvalid,
  output logic [63:0] rdata,
  output logic        rlast
);

  logic [31:0] lfsr_state;
  logic [63:0] beat_addr;
  logic [8:0]  beats_left;
  logic        busy;
  logic        ar_seen;
  logic [1:0]  ar_delay;
  logic        ar_fire;
  logic        r_fire;
  logic [63:0] addr_in;
  logic [7:0]  len_in;

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // fixed mix of the whole byte address
  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [31:0] x;
    x = addr[31:0] ^ {addr[47:32], addr[63:48]};
    return {x[18:0], x[31:19]} ^ 32'hC3A5_1E69;
  endfunction

  initial begin
    arready    = 1'b0;
    rvalid     = 1'b0;
    rdata      = '0;
    rlast      = 1'b0;
    lfsr_state = 32'd69846;
    busy       = 1'b0;
    ar_seen    = 1'b0;
    ar_delay   = 2'd0;
    beats_left = '0;
    beat_addr  = '0;
  end

  always @(posedge ap_clk) begin
    ar_fire = arvalid & arready;  // handshakes seen at this edge
    r_fire  = rvalid & rready;
    addr_in = araddr;
    len_in  = arlen;
    #1;
    if (areset) begin
      arready    = 1'b0;
      rvalid     = 1'b0;
      rlast      = 1'b0;
      busy       = 1'b0;
      ar_seen    = 1'b0;
      lfsr_state = 32'd69846;
    end else begin
      if (ar_fire) begin
        busy       = 1'b1;
        arready    = 1'b0;
        ar_seen    = 1'b0;
        beat_addr  = addr_in;
        beats_left = 9'(len_in) + 9'd1;
      end else if (!busy && arvalid) begin
        if (!ar_seen) begin
          ar_seen    = 1'b1;
          lfsr_state = lfsr_step(lfsr_state);
          ar_delay[0] = lfsr_state[0];
          lfsr_state = lfsr_step(lfsr_state);
          ar_delay[1] = lfsr_state[0];
        end else if (ar_delay == 2'd0) begin
          arready = 1'b1;
        end else begin
          ar_delay = ar_delay - 2'd1;
        end
      end
      if (r_fire) begin
        beat_addr  = beat_addr + 64'd8;
        beats_left = beats_left - 9'd1;
        if (beats_left == 9'd0) begin
          busy = 1'b0;
        end
      end
      if (busy) begin
        lfsr_state = lfsr_step(lfsr_state);
        rvalid     = lfsr_state[0];  // random stall
        rdata      = {mem_word(beat_addr + 64'd4), mem_word(beat_addr)};  // low word first
        rlast      = (beats_left == 9'd1);
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_control_plane.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_control_plane;

  localparam int WAIT_LIMIT = 200;  // cycles per wait

  logic        ap_clk;
  logic        areset;
  logic [5:0]  awaddr;
  logic        awvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        bready;
  logic [5:0]  araddr;
  logic        arvalid;
  logic        rready;
  logic        awready;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        interrupt;
  logic        m_axi_arready;
  logic        m_axi_rvalid;
  logic [63:0] m_axi_rdata;
  logic        m_axi_rlast;
  logic        m_axi_arvalid;
  logic [63:0] m_axi_araddr;
  logic [7:0]  m_axi_arlen;
  logic        m_axi_rready;
  logic        done_steady;
  logic [1:0]  clken_pc;
  logic [1:0]  load_pc;
  logic [1:0]  incr_pc;
  logic [23:0] load_value_pc;
  logic [31:0] cycle_register;
  logic [63:0] instr;
  logic        done_loader;

  int          errors       = 0;
  int          test_start   = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          done_count   = 0;
  int          burst_count  = 0;
  logic [63:0] last_araddr;
  logic [7:0]  last_arlen;
  logic [63:0] cur_ptr;
  logic        watch_instr;
  logic [11:0] ref_pc [cp_pkg::NUM_COL];

  control_plane u_control_plane (.*);

  tb_axi_mem u_axi_mem (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .arvalid (m_axi_arvalid),
    .araddr  (m_axi_araddr),
    .arlen   (m_axi_arlen),
    .rready  (m_axi_rready),
    .arready (m_axi_arready),
    .rvalid  (m_axi_rvalid),
    .rdata   (m_axi_rdata),
    .rlast   (m_axi_rlast)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  function automatic logic [31:0] expected_instr(input logic [63:0] base, input int idx);
    return u_axi_mem.mem_word(base + 64'(4 * (idx % cp_pkg::TABLE_DEPTH)));
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_report(input string what);
    $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    errors++;
  endtask

  task automatic tick();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  // bus monitors sampled mid-cycle
  always @(negedge ap_clk) begin
    if (done_loader) begin
      done_count++;
    end
    if (m_axi_arvalid && m_axi_arready) begin
      burst_count++;
      last_araddr = m_axi_araddr;
      last_arlen  = m_axi_arlen;
    end
  end

  // expected PC per column
  always @(posedge ap_clk) begin
    for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
      if (areset) begin
        ref_pc[c] <= '0;
      end else if (clken_pc[c]) begin
        if (load_pc[c]) begin
          ref_pc[c] <= load_value_pc[c*cp_pkg::PC_W +: cp_pkg::PC_W];
        end else if (incr_pc[c]) begin
          ref_pc[c] <= ref_pc[c] + 12'd1;
        end
      end
    end
  end

  // compares instr with the expected table entry every cycle
  always @(negedge ap_clk) begin
    if (watch_instr) begin
      for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
        check($sformatf("instr[%0d]", c), 64'(instr[c*cp_pkg::INSTR_W +: cp_pkg::INSTR_W]),
              done_steady ? 64'd0 : 64'(expected_instr(cur_ptr, int'(ref_pc[c][4:0]))));
      end
    end
  end

  task automatic axil_write(input logic [5:0] addr, input logic [31:0] data);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (!bvalid && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!bvalid) begin
      timeout_report("write response");
    end else begin
      check("bresp", 64'(bresp), 64'd0);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    tick();  // b handshake
    bready  = 1'b0;
  endtask

  task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    n = 0;
    while (!rvalid && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!rvalid) begin
      timeout_report("read response");
    end else begin
      check("rresp", 64'(rresp), 64'd0);
    end
    data    = rdata;
    arvalid = 1'b0;
    rready  = 1'b1;
    tick();
    rready  = 1'b0;
  endtask

  task automatic start_load(input logic [63:0] base);
    int d0;
    int b0;
    int n;
    axil_write(cp_pkg::ADDR_PTR_LO, base[31:0]);
    axil_write(cp_pkg::ADDR_PTR_HI, base[63:32]);
    d0 = done_count;
    b0 = burst_count;
    axil_write(cp_pkg::ADDR_CTRL, 32'h1);
    n = 0;
    while (done_count == d0 && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (done_count == d0) begin
      timeout_report("done_loader pulse");
    end
    repeat (4) tick();  // room for a stray second pulse
    check("done_loader pulses", 64'(done_count - d0), 64'd1);
    check("bursts", 64'(burst_count - b0), 64'd1);
    check("m_axi_araddr", last_araddr, base);
    check("m_axi_arlen", 64'(last_arlen), 64'(cp_pkg::BURST_LEN - 1));
  endtask

  task automatic drive_col(input int c, input logic en, input logic ld, input logic inc,
                           input logic [11:0] value);
    clken_pc[c] = en;
    load_pc[c]  = ld;
    incr_pc[c]  = inc;
    load_value_pc[c*cp_pkg::PC_W +: cp_pkg::PC_W] = value;
  endtask

  task automatic check_col(input int c, input int idx);
    check($sformatf("instr[%0d]", c), 64'(instr[c*cp_pkg::INSTR_W +: cp_pkg::INSTR_W]),
          64'(expected_instr(cur_ptr, idx)));
  endtask

  task automatic sweep_columns();
    for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
      for (int i = 0; i < cp_pkg::TABLE_DEPTH; i++) begin
        drive_col(c, 1'b1, 1'b1, 1'b0, 12'(i));
        tick();
        drive_col(c, 1'b0, 1'b0, 1'b0, 12'd0);
        check_col(c, i);
      end
    end
  endtask

  task automatic wait_interrupt();
    int n;
    n = 0;
    while (!interrupt && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!interrupt) begin
      timeout_report("interrupt");
    end
  endtask

  initial begin
    logic [31:0] rd_val;
    areset        = 1'b1;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    done_steady   = 1'b0;
    clken_pc      = '0;
    load_pc       = '0;
    incr_pc       = '0;
    load_value_pc = '0;
    cur_ptr       = 64'h0000_00A5_0001_2340;
    watch_instr   = 1'b0;
    repeat (5) @(posedge ap_clk);
    #1;
    areset = 1'b0;
    tick();

    check("m_axi_arvalid", 64'(m_axi_arvalid), 64'd0);
    check("done_loader", 64'(done_loader), 64'd0);
    check("interrupt", 64'(interrupt), 64'd0);
    axil_read(cp_pkg::ADDR_CTRL, rd_val);
    check("ctrl", 64'(rd_val), 64'h4);  // idle only
    axil_write(cp_pkg::ADDR_PTR_LO, cur_ptr[31:0]);
    axil_write(cp_pkg::ADDR_PTR_HI, cur_ptr[63:32]);
    axil_read(cp_pkg::ADDR_PTR_LO, rd_val);
    check("ptr_lo", 64'(rd_val), 64'(cur_ptr[31:0]));
    axil_read(cp_pkg::ADDR_PTR_HI, rd_val);
    check("ptr_hi", 64'(rd_val), 64'(cur_ptr[63:32]));
    finish_test("reset_and_registers");

    start_load(cur_ptr);
    axil_read(cp_pkg::ADDR_CTRL, rd_val);
    check("ctrl", 64'(rd_val), 64'hE);  // done, idle, ready
    axil_read(cp_pkg::ADDR_CTRL, rd_val);
    check("ctrl", 64'(rd_val), 64'h4);
    check("cycle_register >= BURST_LEN",
          64'(cycle_register >= 32'(cp_pkg::BURST_LEN)), 64'd1);
    finish_test("image_load");

    watch_instr = 1'b1;
    sweep_columns();
    for (int c = 0; c < cp_pkg::NUM_COL; c++) begin
      drive_col(c, 1'b1, 1'b1, 1'b0, 12'd33);
      tick();
      drive_col(c, 1'b0, 1'b0, 1'b0, 12'd0);
      check_col(c, 1);  // wraps to index 1
    end
    finish_test("pc_load_sweep");

    drive_col(0, 1'b1, 1'b1, 1'b0, 12'd5);
    tick();
    check_col(0, 5);
    drive_col(0, 1'b1, 1'b0, 1'b1, 12'd0);
    for (int k = 1; k <= 3; k++) begin
      tick();
      check_col(0, 5 + k);
    end
    drive_col(0, 1'b0, 1'b0, 1'b1, 12'd0);  // clken low holds
    tick();
    tick();
    check_col(0, 8);
    drive_col(0, 1'b1, 1'b1, 1'b1, 12'd20);  // load over incr
    tick();
    drive_col(0, 1'b0, 1'b0, 1'b0, 12'd0);
    check_col(0, 20);
    drive_col(1, 1'b1, 1'b1, 1'b0, 12'd31);
    tick();
    drive_col(1, 1'b1, 1'b0, 1'b1, 12'd0);
    tick();
    check_col(1, 0);
    tick();
    drive_col(1, 1'b0, 1'b0, 1'b0, 12'd0);
    check_col(1, 1);
    check_col(0, 20);
    finish_test("pc_increment_and_hold");

    axil_write(cp_pkg::ADDR_ISR, 32'h1);  // done status left from the first load
    axil_write(cp_pkg::ADDR_GIE, 32'h1);
    axil_write(cp_pkg::ADDR_IER, 32'h1);
    check("interrupt", 64'(interrupt), 64'd0);
    watch_instr = 1'b0;  // table reads zero while loading
    cur_ptr = 64'h0000_0001_0004_5678;
    start_load(cur_ptr);
    wait_interrupt();
    check("interrupt", 64'(interrupt), 64'd1);
    axil_write(cp_pkg::ADDR_ISR, 32'h1);
    check("interrupt", 64'(interrupt), 64'd0);
    watch_instr = 1'b1;
    sweep_columns();
    finish_test("interrupt_and_reload");

    drive_col(0, 1'b1, 1'b1, 1'b0, 12'd3);
    drive_col(1, 1'b1, 1'b1, 1'b0, 12'd7);
    tick();
    done_steady = 1'b1;
    drive_col(0, 1'b1, 1'b0, 1'b1, 12'd0);
    drive_col(1, 1'b1, 1'b0, 1'b1, 12'd0);
    tick();
    tick();
    drive_col(0, 1'b0, 1'b0, 1'b0, 12'd0);
    drive_col(1, 1'b0, 1'b0, 1'b0, 12'd0);
    check("instr", instr, 64'd0);
    done_steady = 1'b0;
    tick();
    check_col(0, 5);
    check_col(1, 9);
    finish_test("done_steady_nop");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
cp_pkg.sv
instr_table_if.sv
control_regs.sv
instr_fetch.sv
instr_table.sv
pc_sequencer.sv
control_plane.sv
tb_axi_mem.sv
tb_control_plane.sv

/* run.sh */
#!/bin/sh
# build and run the control plane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_control_plane \
  -o tb_control_plane
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_control_plane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
